//--- ex_pkg.sv
package ex_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // alu op is one-hot, these are bit positions
    localparam int ALU_OP_W = 12;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // multiply op codes
    localparam int MUL_OP_W = 2;
    localparam logic [MUL_OP_W-1:0] MUL_LO  = 2'd0;   // low word
    localparam logic [MUL_OP_W-1:0] MUL_HI  = 2'd1;   // signed high word
    localparam logic [MUL_OP_W-1:0] MUL_HIU = 2'd2;   // unsigned high word

    localparam int MUL_STEPS = 32;   // one multiplier bit per cycle

endpackage

//--- operand_fwd.sv
`timescale 1ns/10ps

module operand_fwd (
    input  logic [ex_pkg::REG_AW-1:0] rf_raddr1,
    input  logic [ex_pkg::REG_AW-1:0] rf_raddr2,
    input  logic [ex_pkg::XLEN-1:0]   rj_value_rf,
    input  logic [ex_pkg::XLEN-1:0]   rkd_value_rf,
    input  logic                      fwd1_valid,
    input  logic                      fwd1_we,
    input  logic [ex_pkg::REG_AW-1:0] fwd1_dest,
    input  logic [ex_pkg::XLEN-1:0]   fwd1_data,
    input  logic                      fwd2_valid,
    input  logic                      fwd2_we,
    input  logic [ex_pkg::REG_AW-1:0] fwd2_dest,
    input  logic [ex_pkg::XLEN-1:0]   fwd2_data,
    input  logic [ex_pkg::XLEN-1:0]   pc,
    input  logic [ex_pkg::XLEN-1:0]   imm,
    input  logic                      src1_is_pc,
    input  logic                      src2_is_imm,
    input  logic                      src2_is_4,
    output logic [ex_pkg::XLEN-1:0]   rj_value,
    output logic [ex_pkg::XLEN-1:0]   rkd_value,
    output logic [ex_pkg::XLEN-1:0]   src1,
    output logic [ex_pkg::XLEN-1:0]   src2
);
    import ex_pkg::*;

    logic fwd1_rj;
    logic fwd2_rj;
    logic fwd1_rkd;
    logic fwd2_rkd;

    // r0 is hardwired, a write to it is never forwarded
    function automatic logic hit(input logic valid, input logic we,
                                 input logic [REG_AW-1:0] wdest,
                                 input logic [REG_AW-1:0] raddr);
        return valid && we && (wdest != '0) && (wdest == raddr);
    endfunction

    assign fwd1_rj  = hit(fwd1_valid, fwd1_we, fwd1_dest, rf_raddr1);
    assign fwd2_rj  = hit(fwd2_valid, fwd2_we, fwd2_dest, rf_raddr1);
    assign fwd1_rkd = hit(fwd1_valid, fwd1_we, fwd1_dest, rf_raddr2);
    assign fwd2_rkd = hit(fwd2_valid, fwd2_we, fwd2_dest, rf_raddr2);

    // lane 2 is the younger write
    assign rj_value  = fwd2_rj  ? fwd2_data : fwd1_rj  ? fwd1_data : rj_value_rf;
    assign rkd_value = fwd2_rkd ? fwd2_data : fwd1_rkd ? fwd1_data : rkd_value_rf;

    assign src1 = src1_is_pc ? pc : rj_value;
    assign src2 = src2_is_imm ? imm :
                  src2_is_4   ? XLEN'(4) :   // link address pc+4
                  rkd_value;

endmodule

//--- alu.sv
`timescale 1ns/10ps

module alu (
    input  logic [ex_pkg::ALU_OP_W-1:0] alu_op,
    input  logic [ex_pkg::XLEN-1:0]     alu_src1,
    input  logic [ex_pkg::XLEN-1:0]     alu_src2,
    output logic [ex_pkg::XLEN-1:0]     alu_result,
    output logic                        zero,
    output logic                        less
);
    import ex_pkg::*;

    logic            do_sub;
    logic [XLEN-1:0] adder_b;
    logic [XLEN:0]   adder_sum;   // top bit is carry out
    logic            slt_res;
    logic            sltu_res;
    logic [4:0]      shamt;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;

    // sub and both compares go through the same adder
    assign do_sub    = alu_op[ALU_SUB] | alu_op[ALU_SLT] | alu_op[ALU_SLTU];
    assign adder_b   = do_sub ? ~alu_src2 : alu_src2;
    assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b} + (XLEN+1)'(do_sub);

    // signs differ: src1 negative means less, else look at the difference
    assign slt_res  = (alu_src1[XLEN-1] & ~alu_src2[XLEN-1])
                    | (~(alu_src1[XLEN-1] ^ alu_src2[XLEN-1]) & adder_sum[XLEN-1]);
    assign sltu_res = ~adder_sum[XLEN];   // borrow out

    assign zero = (adder_sum[XLEN-1:0] == '0);
    assign less = alu_op[ALU_SLTU] ? sltu_res : slt_res;

    assign shamt   = alu_src2[4:0];
    assign sll_res = alu_src1 << shamt;
    assign srl_res = alu_src1 >> shamt;
    assign sra_res = XLEN'($signed(alu_src1) >>> shamt);

    assign alu_result = ({XLEN{alu_op[ALU_ADD] | alu_op[ALU_SUB]}} & adder_sum[XLEN-1:0])
                      | ({XLEN{alu_op[ALU_SLT]}}  & XLEN'(slt_res))
                      | ({XLEN{alu_op[ALU_SLTU]}} & XLEN'(sltu_res))
                      | ({XLEN{alu_op[ALU_AND]}}  & (alu_src1 & alu_src2))
                      | ({XLEN{alu_op[ALU_NOR]}}  & ~(alu_src1 | alu_src2))
                      | ({XLEN{alu_op[ALU_OR]}}   & (alu_src1 | alu_src2))
                      | ({XLEN{alu_op[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
                      | ({XLEN{alu_op[ALU_SLL]}}  & sll_res)
                      | ({XLEN{alu_op[ALU_SRL]}}  & srl_res)
                      | ({XLEN{alu_op[ALU_SRA]}}  & sra_res)
                      | ({XLEN{alu_op[ALU_LUI]}}  & alu_src2);   // imm already shifted

endmodule

//--- branch_cond.sv
`timescale 1ns/10ps

module branch_cond (
    input  logic                    ds_valid,
    input  logic                    may_jump,
    input  logic                    use_rj_value,
    input  logic                    use_less,
    input  logic                    need_less,
    input  logic                    use_zero,
    input  logic                    need_zero,
    input  logic                    pre_jump,
    input  logic                    less,
    input  logic                    zero,
    input  logic [ex_pkg::XLEN-1:0] pc,
    input  logic [ex_pkg::XLEN-1:0] rj_value,
    input  logic [ex_pkg::XLEN-1:0] imm,
    output logic                    br_flush,
    output logic [ex_pkg::XLEN-1:0] br_target
);
    import ex_pkg::*;

    logic            less_ok;
    logic            zero_ok;
    logic            taken;
    logic [XLEN-1:0] base;

    // an unused flag always passes
    assign less_ok = !use_less || (less == need_less);
    assign zero_ok = !use_zero || (zero == need_zero);
    assign taken   = may_jump && less_ok && zero_ok;

    assign base      = use_rj_value ? rj_value : pc;   // jirl is register relative
    assign br_target = taken ? base + imm : pc + XLEN'(4);

    // decode guessed wrong
    assign br_flush = ds_valid && (taken != pre_jump);

endmodule

//--- mul_unit.sv
`timescale 1ns/10ps

module mul_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mul_start,
    input  logic [ex_pkg::MUL_OP_W-1:0] mul_op,
    input  logic [ex_pkg::XLEN-1:0]     mul_a,
    input  logic [ex_pkg::XLEN-1:0]     mul_b,
    input  logic                        accept,
    output logic [ex_pkg::XLEN-1:0]     mul_result,
    output logic                        mul_done
);
    import ex_pkg::*;

    logic                           busy;
    logic                           load;
    logic [$clog2(MUL_STEPS+1)-1:0] step;
    logic [2*XLEN-1:0]              acc;
    logic [2*XLEN-1:0]              mcand;
    logic [XLEN-1:0]                mplier;
    logic [MUL_OP_W-1:0]            op_r;
    logic                           neg_r;
    logic                           is_signed;
    logic [XLEN-1:0]                mag_a;
    logic [XLEN-1:0]                mag_b;

    assign is_signed = (mul_op == MUL_HI);
    assign mag_a     = (is_signed && mul_a[XLEN-1]) ? -mul_a : mul_a;
    assign mag_b     = (is_signed && mul_b[XLEN-1]) ? -mul_b : mul_b;
    assign load      = mul_start && !busy && !mul_done;   // no restart until accepted

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            mul_done <= 1'b0;
            step     <= '0;
        end
        else if (busy)
        begin
            step <= step + 1'b1;
            if (step == MUL_STEPS)   // sign fix-up cycle
            begin
                busy     <= 1'b0;
                mul_done <= 1'b1;
            end
        end
        else if (load)
        begin
            busy <= 1'b1;
            step <= '0;
        end
        else if (accept)
            mul_done <= 1'b0;
    end

    // shift-add on magnitudes
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            acc    <= '0;
            mcand  <= {{XLEN{1'b0}}, mag_a};
            mplier <= mag_b;
            op_r   <= mul_op;
            neg_r  <= is_signed && (mul_a[XLEN-1] ^ mul_b[XLEN-1]);
        end
        else if (busy)
        begin
            if (step == MUL_STEPS)
                acc <= neg_r ? -acc : acc;
            else
            begin
                if (mplier[0])
                    acc <= acc + mcand;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
        end
    end

    always_comb
    begin
        case (op_r)
            MUL_LO:          mul_result = acc[XLEN-1:0];
            MUL_HI, MUL_HIU: mul_result = acc[2*XLEN-1:XLEN];
            default:         mul_result = acc[XLEN-1:0];
        endcase
    end

endmodule

//--- ex_result_reg.sv
`timescale 1ns/10ps

module ex_result_reg (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ds_valid,
    input  logic                      my_ok,
    input  logic                      another_ok,
    input  logic                      ws_ready,
    input  logic                      gr_we,
    input  logic [ex_pkg::REG_AW-1:0] dest,
    input  logic [ex_pkg::XLEN-1:0]   pc,
    input  logic [ex_pkg::XLEN-1:0]   final_result,
    output logic                      es_ready,
    output logic                      es_to_ws_valid,
    output logic                      ws_we,
    output logic [ex_pkg::REG_AW-1:0] ws_dest,
    output logic [ex_pkg::XLEN-1:0]   ws_data,
    output logic [ex_pkg::XLEN-1:0]   ws_pc
);
    import ex_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_self,
        st_wait_partner
    } state_t;

    state_t          state;
    state_t          state_nxt;
    logic            held;
    logic            accept;
    logic [XLEN-1:0] hold_r;
    logic [XLEN-1:0] issue_result;

    assign held         = (state == st_wait_partner);
    assign es_ready     = ws_ready && my_ok && another_ok;   // both lanes leave together
    assign accept       = ds_valid && es_ready;
    assign issue_result = held ? hold_r : final_result;

    // pairing with the other lane
    always_comb
    begin
        state_nxt = state;
        if (accept)
            state_nxt = st_idle;
        else if (ds_valid)
        begin
            case (state)
                st_idle, st_wait_self:
                begin
                    if (!my_ok)
                        state_nxt = st_wait_self;
                    else if (!another_ok)
                        state_nxt = st_wait_partner;
                    else
                        state_nxt = st_idle;   // only writeback is stalling
                end
                st_wait_partner: state_nxt = st_wait_partner;
                default:         state_nxt = st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    // freeze own result while the partner catches up
    always_ff @(posedge clk)
    begin
        if (!held && state_nxt == st_wait_partner)
            hold_r <= final_result;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            es_to_ws_valid <= 1'b0;
        else if (ws_ready)
            es_to_ws_valid <= accept;   // held as is under back-pressure
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            ws_we   <= gr_we;
            ws_dest <= dest;
            ws_data <= issue_result;
            ws_pc   <= pc;
        end
    end

endmodule

//--- ex_stage.sv
`timescale 1ns/10ps

module ex_stage (
    input  logic                        clk,
    input  logic                        reset,
    // from decode
    input  logic                        ds_valid,
    output logic                        es_ready,
    input  logic [ex_pkg::ALU_OP_W-1:0] alu_op,
    input  logic                        mul_en,
    input  logic [ex_pkg::MUL_OP_W-1:0] mul_op,
    input  logic                        src1_is_pc,
    input  logic                        src2_is_imm,
    input  logic                        src2_is_4,
    input  logic [ex_pkg::XLEN-1:0]     imm,
    input  logic [ex_pkg::XLEN-1:0]     pc,
    input  logic [ex_pkg::REG_AW-1:0]   rf_raddr1,
    input  logic [ex_pkg::REG_AW-1:0]   rf_raddr2,
    input  logic [ex_pkg::XLEN-1:0]     rj_value_rf,
    input  logic [ex_pkg::XLEN-1:0]     rkd_value_rf,
    input  logic                        gr_we,
    input  logic [ex_pkg::REG_AW-1:0]   dest,
    input  logic                        may_jump,
    input  logic                        use_rj_value,
    input  logic                        use_less,
    input  logic                        need_less,
    input  logic                        use_zero,
    input  logic                        need_zero,
    input  logic                        pre_jump,
    // forwarding, one per writeback lane
    input  logic                        fwd1_valid,
    input  logic                        fwd1_we,
    input  logic [ex_pkg::REG_AW-1:0]   fwd1_dest,
    input  logic [ex_pkg::XLEN-1:0]     fwd1_data,
    input  logic                        fwd2_valid,
    input  logic                        fwd2_we,
    input  logic [ex_pkg::REG_AW-1:0]   fwd2_dest,
    input  logic [ex_pkg::XLEN-1:0]     fwd2_data,
    // to writeback
    output logic                        es_to_ws_valid,
    output logic                        ws_we,
    output logic [ex_pkg::REG_AW-1:0]   ws_dest,
    output logic [ex_pkg::XLEN-1:0]     ws_data,
    output logic [ex_pkg::XLEN-1:0]     ws_pc,
    input  logic                        ws_ready,
    // lane pairing
    input  logic                        another_ok,
    output logic                        my_ok,
    output logic                        br_flush,
    output logic [ex_pkg::XLEN-1:0]     br_target
);
    import ex_pkg::*;

    logic [XLEN-1:0] rj_value;
    logic [XLEN-1:0] rkd_value;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_result;
    logic            zero;
    logic            less;
    logic            br_mispredict;
    logic [XLEN-1:0] mul_result;
    logic            mul_done;
    logic            mul_start;
    logic            accept;
    logic [XLEN-1:0] final_result;

    assign accept       = ds_valid && es_ready;
    assign my_ok        = !ds_valid || !mul_en || mul_done;
    assign mul_start    = ds_valid && mul_en && !mul_done;   // ignored while unit is busy
    assign final_result = mul_en ? mul_result : alu_result;
    assign br_flush     = br_mispredict && accept;

    operand_fwd u_operand_fwd (
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .rj_value_rf  (rj_value_rf),
        .rkd_value_rf (rkd_value_rf),
        .fwd1_valid   (fwd1_valid),
        .fwd1_we      (fwd1_we),
        .fwd1_dest    (fwd1_dest),
        .fwd1_data    (fwd1_data),
        .fwd2_valid   (fwd2_valid),
        .fwd2_we      (fwd2_we),
        .fwd2_dest    (fwd2_dest),
        .fwd2_data    (fwd2_data),
        .pc           (pc),
        .imm          (imm),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .src2_is_4    (src2_is_4),
        .rj_value     (rj_value),
        .rkd_value    (rkd_value),
        .src1         (src1),
        .src2         (src2)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (src1),
        .alu_src2   (src2),
        .alu_result (alu_result),
        .zero       (zero),
        .less       (less)
    );

    branch_cond u_branch_cond (
        .ds_valid     (ds_valid),
        .may_jump     (may_jump),
        .use_rj_value (use_rj_value),
        .use_less     (use_less),
        .need_less    (need_less),
        .use_zero     (use_zero),
        .need_zero    (need_zero),
        .pre_jump     (pre_jump),
        .less         (less),
        .zero         (zero),
        .pc           (pc),
        .rj_value     (rj_value),
        .imm          (imm),
        .br_flush     (br_mispredict),
        .br_target    (br_target)
    );

    // multiplies read the registers directly
    mul_unit u_mul_unit (
        .clk        (clk),
        .reset      (reset),
        .mul_start  (mul_start),
        .mul_op     (mul_op),
        .mul_a      (rj_value),
        .mul_b      (rkd_value),
        .accept     (accept),
        .mul_result (mul_result),
        .mul_done   (mul_done)
    );

    ex_result_reg u_ex_result_reg (
        .clk            (clk),
        .reset          (reset),
        .ds_valid       (ds_valid),
        .my_ok          (my_ok),
        .another_ok     (another_ok),
        .ws_ready       (ws_ready),
        .gr_we          (gr_we),
        .dest           (dest),
        .pc             (pc),
        .final_result   (final_result),
        .es_ready       (es_ready),
        .es_to_ws_valid (es_to_ws_valid),
        .ws_we          (ws_we),
        .ws_dest        (ws_dest),
        .ws_data        (ws_data),
        .ws_pc          (ws_pc)
    );

endmodule

//--- ex_stage_checker.sv
`timescale 1ns/10ps

module ex_stage_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      ds_valid,
    input logic                      ws_ready,
    input logic                      es_to_ws_valid,
    input logic                      ws_we,
    input logic [ex_pkg::REG_AW-1:0] ws_dest,
    input logic [ex_pkg::XLEN-1:0]   ws_data,
    input logic [ex_pkg::XLEN-1:0]   ws_pc,
    input logic                      br_flush
);

    // nothing goes to writeback straight out of reset
    valid_after_reset: assert property (@(posedge clk) reset |=> !es_to_ws_valid)
        else $error("es_to_ws_valid high in the cycle after reset");

    ws_hold: assert property (@(posedge clk) disable iff (reset)
        !ws_ready |=> $stable(es_to_ws_valid) && $stable(ws_we) && $stable(ws_dest)
                      && $stable(ws_data) && $stable(ws_pc))
        else $error("writeback outputs changed while ws_ready was low");

    flush_needs_valid: assert property (@(posedge clk) disable iff (reset)
        br_flush |-> ds_valid ##1 es_to_ws_valid)   // flush only for an accepted instruction
        else $error("br_flush raised without an accepted instruction");

endmodule

bind ex_stage ex_stage_checker u_checker (.*);

//--- tb_ex_stage.sv
`timescale 1ns/10ps

module tb_ex_stage;
    import ex_pkg::*;

    logic                clk = 1'b0;
    logic                reset;
    logic                ds_valid;
    logic [ALU_OP_W-1:0] alu_op;
    logic                mul_en;
    logic [MUL_OP_W-1:0] mul_op;
    logic                src1_is_pc;
    logic                src2_is_imm;
    logic                src2_is_4;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     pc;
    logic [REG_AW-1:0]   rf_raddr1;
    logic [REG_AW-1:0]   rf_raddr2;
    logic [XLEN-1:0]     rj_value_rf;
    logic [XLEN-1:0]     rkd_value_rf;
    logic                gr_we;
    logic [REG_AW-1:0]   dest;
    logic                may_jump;
    logic                use_rj_value;
    logic                use_less;
    logic                need_less;
    logic                use_zero;
    logic                need_zero;
    logic                pre_jump;
    logic                fwd1_valid;
    logic                fwd1_we;
    logic [REG_AW-1:0]   fwd1_dest;
    logic [XLEN-1:0]     fwd1_data;
    logic                fwd2_valid;
    logic                fwd2_we;
    logic [REG_AW-1:0]   fwd2_dest;
    logic [XLEN-1:0]     fwd2_data;
    logic                ws_ready;
    logic                another_ok;
    logic                es_ready;
    logic                es_to_ws_valid;
    logic                ws_we;
    logic [REG_AW-1:0]   ws_dest;
    logic [XLEN-1:0]     ws_data;
    logic [XLEN-1:0]     ws_pc;
    logic                my_ok;
    logic                br_flush;
    logic [XLEN-1:0]     br_target;

    logic [31:0]         lfsr;
    int                  mismatches;
    int                  others;
    logic                flush_seen;   // br_flush in the accept cycle
    logic [XLEN-1:0]     target_seen;

    ex_stage u_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_model(input int op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_AND:  return a & b;
            ALU_NOR:  return ~(a | b);
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            default:  return b;   // lui
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            mismatches++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        {ds_valid, mul_en, src1_is_pc, src2_is_imm, src2_is_4, gr_we} = '0;
        {may_jump, use_rj_value, use_less, need_less, use_zero, need_zero, pre_jump} = '0;
        alu_op = '0;
        mul_op = '0;
        {imm, pc, rj_value_rf, rkd_value_rf} = '0;
        {rf_raddr1, rf_raddr2, dest} = '0;
        {fwd1_valid, fwd1_we, fwd1_dest, fwd1_data} = '0;
        {fwd2_valid, fwd2_we, fwd2_dest, fwd2_data} = '0;
        ws_ready   = 1'b1;
        another_ok = 1'b1;
    endtask

    task automatic load_alu(input int op, input logic [31:0] a, input logic [31:0] b);
        alu_op       = ALU_OP_W'(1) << op;
        rj_value_rf  = a;
        rkd_value_rf = b;
        rf_raddr1    = 5'd1;
        rf_raddr2    = 5'd2;
        dest         = 5'd3;
        gr_we        = 1'b1;
        pc           = 32'h1c00_0100;
        ds_valid     = 1'b1;
    endtask

    // counts the cycles es_ready stays low, returns just after the accept edge
    task automatic wait_accept(output int stalls);
        int n;
        n = 0;
        @(negedge clk);
        while (!es_ready && n < 2 * MUL_STEPS + 8)
        begin
            n++;
            @(negedge clk);
        end
        assert (es_ready)
        else
        begin
            others++;
            $display("Error at %0t: es_ready never rose for a valid instruction", $time);
        end
        flush_seen  = br_flush;
        target_seen = br_target;
        stalls      = n;
        next_cycle();
        ds_valid = 1'b0;
    endtask

    task automatic collect_result(input logic [31:0] exp);
        int stalls;
        wait_accept(stalls);
        @(negedge clk);
        check_val("es_to_ws_valid", es_to_ws_valid, 1'b1);
        check_val("ws_data", ws_data, exp);
        check_val("ws_dest", ws_dest, 5'd3);
        check_val("ws_we", ws_we, 1'b1);
        check_val("ws_pc", ws_pc, 32'h1c00_0100);
        next_cycle();
    endtask

    task automatic run_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        for (int op = 0; op < ALU_OP_W; op++)
        begin
            for (int k = 0; k < 3; k++)
            begin
                a = rand_word(32);
                b = rand_word(32);
                load_alu(op, a, b);
                collect_result(alu_model(op, a, b));
                @(negedge clk);
                check_val("es_to_ws_valid", es_to_ws_valid, 1'b0);   // one-cycle pulse
                next_cycle();
            end
        end
    endtask

    task automatic forwarding_cases();
        logic [31:0] rf_v;
        logic [31:0] rk_v;
        logic [31:0] d1;
        logic [31:0] d2;
        rf_v = rand_word(32);
        rk_v = rand_word(32);
        d1   = rand_word(32);
        d2   = rand_word(32);
        {fwd1_valid, fwd1_we, fwd1_dest, fwd1_data} = {1'b1, 1'b1, 5'd7, d1};
        {fwd2_valid, fwd2_we, fwd2_dest, fwd2_data} = {1'b1, 1'b1, 5'd7, d2};
        load_alu(ALU_ADD, rf_v, rk_v);
        rf_raddr1 = 5'd7;
        collect_result(d2 + rk_v);   // both match, lane 2 is newer
        fwd2_valid = 1'b0;
        load_alu(ALU_ADD, rf_v, rk_v);
        rf_raddr1 = 5'd7;
        collect_result(d1 + rk_v);
        fwd2_valid = 1'b1;
        fwd1_dest  = 5'd0;
        fwd2_dest  = 5'd0;
        load_alu(ALU_ADD, rf_v, rk_v);
        rf_raddr1 = 5'd0;
        collect_result(rf_v + rk_v);   // r0 never forwarded
        fwd1_valid = 1'b0;
        fwd2_valid = 1'b0;
    endtask

    task automatic branch_sweep();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] off;
        logic [31:0] pcv;
        logic        lm;
        logic        zm;
        logic        tk;
        logic        pj;
        int          stalls;
        for (int c = 0; c < 32; c++)
        begin
            a   = rand_word(32);
            b   = rand_word(1) ? a : rand_word(32);
            off = rand_word(32);
            pcv = rand_word(30) << 2;
            pj  = rand_word(1);
            load_alu(c[4] ? ALU_SLTU : ALU_SUB, a, b);
            {use_less, need_less, use_zero, need_zero} = {c[0], c[1], c[2], c[3]};
            may_jump = 1'b1;
            pre_jump = pj;
            imm      = off;
            pc       = pcv;
            gr_we    = 1'b0;
            lm = c[4] ? (a < b) : ($signed(a) < $signed(b));
            zm = (a == b);
            tk = (!c[0] || lm == c[1]) && (!c[2] || zm == c[3]);
            wait_accept(stalls);
            check_val("br_flush", flush_seen, tk ^ pj);
            check_val("br_target", target_seen, tk ? pcv + off : pcv + 32'd4);
            next_cycle();
        end
        clear_inputs();
        // jirl, link value pc+4 goes to writeback
        for (int k = 0; k < 4; k++)
        begin
            a   = rand_word(32);
            off = rand_word(32);
            pcv = rand_word(30) << 2;
            pj  = rand_word(1);
            load_alu(ALU_ADD, a, 32'd0);
            {src1_is_pc, src2_is_4, may_jump, use_rj_value} = 4'b1111;
            {imm, pc, pre_jump} = {off, pcv, pj};
            wait_accept(stalls);
            check_val("br_flush", flush_seen, !pj);
            check_val("br_target", target_seen, a + off);
            @(negedge clk);
            check_val("ws_data", ws_data, pcv + 32'd4);
            check_val("ws_pc", ws_pc, pcv);
            next_cycle();
        end
        clear_inputs();
    endtask

    task automatic multiply_checks();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp;
        logic [63:0] full;
        int          stalls;
        for (int m = 0; m < 3; m++)
        begin
            for (int k = 0; k < 3; k++)
            begin
                a = rand_word(32);
                b = rand_word(32);
                if (k == 0)
                    a[31] = 1'b1;
                else if (k == 1)
                    b[31] = 1'b1;
                if (m == MUL_HI)
                    full = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                else
                    full = {32'b0, a} * {32'b0, b};
                exp = (m == MUL_LO) ? full[31:0] : full[63:32];
                load_alu(ALU_ADD, a, b);
                mul_en = 1'b1;
                mul_op = MUL_OP_W'(m);
                @(negedge clk);
                check_val("my_ok", my_ok, 1'b0);   // before the start edge
                wait_accept(stalls);
                check_val("stall cycles", stalls, MUL_STEPS + 1);
                @(negedge clk);
                check_val("ws_data", ws_data, exp);
                next_cycle();
            end
        end
        mul_en = 1'b0;
    endtask

    task automatic pairing_and_backpressure();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        int          stalls;
        a = rand_word(32);
        b = rand_word(32);
        d = rand_word(32);
        another_ok = 1'b0;
        load_alu(ALU_XOR, a, b);
        {fwd2_valid, fwd2_we, fwd2_dest, fwd2_data} = {1'b1, 1'b1, 5'd1, d};
        repeat (4)
        begin
            @(negedge clk);
            check_val("es_ready", es_ready, 1'b0);
            check_val("my_ok", my_ok, 1'b1);
        end
        next_cycle();
        another_ok = 1'b1;
        fwd2_valid = 1'b0;   // held copy still carries the forwarded value
        collect_result(d ^ b);
        load_alu(ALU_OR, a, b);
        wait_accept(stalls);
        ws_ready = 1'b0;
        load_alu(ALU_AND, a, b);
        repeat (4)
        begin
            @(negedge clk);
            check_val("es_ready", es_ready, 1'b0);
            check_val("es_to_ws_valid", es_to_ws_valid, 1'b1);
            check_val("ws_data", ws_data, a | b);   // old result held
        end
        next_cycle();
        ws_ready = 1'b1;
        collect_result(a & b);
    endtask

    initial
    begin
        lfsr       = 32'h99b294d7;
        mismatches = 0;
        others     = 0;
        clear_inputs();
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_val("es_to_ws_valid", es_to_ws_valid, 1'b0);
        next_cycle();
        run_alu_ops();
        forwarding_cases();
        branch_sweep();
        multiply_checks();
        pairing_and_backpressure();
        $display("errors: %0d mismatches, %0d other failures", mismatches, others);
        if (mismatches == 0 && others == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // run length from the test sizes, plus some slack
    initial
    begin
        int test_cycles;
        test_cycles = 2 + 36 * 4 + 3 * 2 + 36 * 2 + 9 * (MUL_STEPS + 4) + 20;
        #(test_cycles * 20 + 400);
        $display("Error at %0t: watchdog expired before the tests completed", $time);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- filelist.f
ex_pkg.sv
operand_fwd.sv
alu.sv
branch_cond.sv
mul_unit.sv
ex_result_reg.sv
ex_stage.sv
ex_stage_checker.sv
tb_ex_stage.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage \
    -f filelist.f -o sim_ex_stage

./obj_dir/sim_ex_stage | tee sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
